//--- sources.f
+incdir+design
design/opx_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/operand_mux.sv
design/alu_stage.sv
design/opx_core.sv
dv/opx_core_props.sv
dv/opx_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = opx_core_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/opx_core_tb.sv
/*
 * Directed table first, then random instructions under random freezes.
 * ex_freeze is only ever driven high together with id_freeze.
 * A wb result counts when ex_freeze is low, the cycle it is written.
 * Expected values come from a register model updated in issue order.
 */

`include "opx_defines.svh"

module opx_core_tb;

	localparam int RAND_COUNT      = 200;
	localparam int RAND_MAX_CYCLES = 4000;
	localparam int DRAIN_TIMEOUT   = 50;

	// One directed row
	typedef struct packed {
		opx_pkg::issue_t iss;
		logic            id_frz;
		logic            ex_frz;
		logic            chk;
		opx_pkg::word_t  exp_data;
	} row_t;

	// One outstanding result
	typedef struct packed {
		logic               rnd;
		logic [31:0]        num;
		opx_pkg::reg_addr_t rd;
		opx_pkg::word_t     data;
	} exp_t;

	logic            clk;
	logic            arst_n;
	logic            id_freeze;
	logic            ex_freeze;
	opx_pkg::issue_t issue;
	opx_pkg::wb_t    wb;

	row_t           rows [$];
	exp_t           exp_q [$];
	exp_t           head;
	opx_pkg::word_t model_regs [`OPX_REGS];
	logic [31:0]    rng;
	int             err_count;
	int             timeout_count;
	int             check_count;
	int             issued;
	logic           timed_out;
	opx_pkg::wb_t   wb_last;
	logic           held_last;

	opx_core opx_core_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.issue     (issue),
		.wb        (wb)
	);

	bind operand_mux opx_core_props opx_core_props_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.sel_a     (sel_a),
		.ex_ctl    (ex_ctl)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ALU rules, SLL by the low 5 bits of B
	function automatic opx_pkg::word_t alu_ref(input opx_pkg::alu_op_t op,
			input opx_pkg::word_t a, input opx_pkg::word_t b);
		case (op)
			opx_pkg::ALU_ADD:  return a + b;
			opx_pkg::ALU_SUB:  return a - b;
			opx_pkg::ALU_AND:  return a & b;
			opx_pkg::ALU_OR:   return a | b;
			opx_pkg::ALU_XOR:  return a ^ b;
			opx_pkg::ALU_SLL:  return a << b[4:0];
			opx_pkg::ALU_MOVB: return b;
			default:           return '0;
		endcase
	endfunction

	function automatic opx_pkg::issue_t make_issue(input opx_pkg::alu_op_t op,
			input opx_pkg::reg_addr_t rd, input opx_pkg::reg_addr_t rs_a,
			input opx_pkg::reg_addr_t rs_b, input logic use_imm, input logic [15:0] imm);
		opx_pkg::issue_t iss;
		iss.valid   = 1'b1;
		iss.op      = op;
		iss.rd      = rd;
		iss.rs_a    = rs_a;
		iss.rs_b    = rs_b;
		iss.use_imm = use_imm;
		iss.imm     = imm;
		return iss;
	endfunction

	// Queue a result and update the model, register 0 never changes
	task automatic expect_result(input logic rnd, input logic [31:0] num,
			input opx_pkg::reg_addr_t rd, input opx_pkg::word_t data);
		exp_q.push_back('{rnd: rnd, num: num, rd: rd, data: data});
		if (rd != '0) begin
			model_regs[rd] = data;
		end
	endtask

	task automatic add_instr(input opx_pkg::alu_op_t op, input opx_pkg::reg_addr_t rd,
			input opx_pkg::reg_addr_t rs_a, input opx_pkg::reg_addr_t rs_b,
			input logic use_imm, input logic [15:0] imm, input opx_pkg::word_t exp_data);
		rows.push_back('{iss: make_issue(op, rd, rs_a, rs_b, use_imm, imm),
			id_frz: 1'b0, ex_frz: 1'b0, chk: 1'b1, exp_data: exp_data});
	endtask

	task automatic add_stall(input logic id_frz, input logic ex_frz,
			input opx_pkg::issue_t iss);
		rows.push_back('{iss: iss, id_frz: id_frz, ex_frz: ex_frz, chk: 1'b0,
			exp_data: '0});
	endtask

	//////////////////////////////////////////////////
	// Directed table
	//////////////////////////////////////////////////

	task automatic build_table();
		// EX forwarding chain
		add_instr(opx_pkg::ALU_MOVB, 4'd1, 4'd0, 4'd0, 1'b1, 16'h0005, 32'h0000_0005);
		add_instr(opx_pkg::ALU_ADD, 4'd2, 4'd1, 4'd0, 1'b1, 16'h0003, 32'h0000_0008);
		add_instr(opx_pkg::ALU_ADD, 4'd3, 4'd2, 4'd2, 1'b0, 16'h0000, 32'h0000_0010);
		// r1 three back from the register file, r3 then by WB forward
		add_instr(opx_pkg::ALU_SUB, 4'd4, 4'd3, 4'd1, 1'b0, 16'h0000, 32'h0000_000b);
		add_instr(opx_pkg::ALU_XOR, 4'd5, 4'd3, 4'd4, 1'b0, 16'h0000, 32'h0000_001b);
		// Negative immediate sign-extended
		add_instr(opx_pkg::ALU_MOVB, 4'd6, 4'd0, 4'd0, 1'b1, 16'hfff0, 32'hffff_fff0);
		add_instr(opx_pkg::ALU_AND, 4'd7, 4'd6, 4'd0, 1'b1, 16'h00ff, 32'h0000_00f0);
		add_instr(opx_pkg::ALU_OR, 4'd8, 4'd5, 4'd6, 1'b0, 16'h0000, 32'hffff_fffb);
		add_instr(opx_pkg::ALU_SLL, 4'd9, 4'd1, 4'd0, 1'b1, 16'h0004, 32'h0000_0050);
		// Decode frozen while r9 drains, r10 keeps saved operands
		add_instr(opx_pkg::ALU_ADD, 4'd10, 4'd9, 4'd9, 1'b0, 16'h0000, 32'h0000_00a0);
		// Issue during freeze is dropped
		add_stall(1'b1, 1'b0, make_issue(opx_pkg::ALU_MOVB, 4'd1, 4'd0, 4'd0, 1'b1,
			16'h7777));
		add_stall(1'b1, 1'b0, '0);
		add_stall(1'b1, 1'b0, '0);
		add_instr(opx_pkg::ALU_SUB, 4'd11, 4'd10, 4'd9, 1'b0, 16'h0000, 32'h0000_0050);
		// Both frozen, then execute released alone
		add_instr(opx_pkg::ALU_ADD, 4'd12, 4'd11, 4'd0, 1'b1, 16'h0001, 32'h0000_0051);
		add_stall(1'b1, 1'b1, '0);
		add_stall(1'b1, 1'b1, '0);
		add_stall(1'b1, 1'b0, '0);
		add_instr(opx_pkg::ALU_ADD, 4'd13, 4'd12, 4'd12, 1'b0, 16'h0000, 32'h0000_00a2);
		// Register 0 as destination and source
		add_instr(opx_pkg::ALU_ADD, 4'd0, 4'd1, 4'd0, 1'b1, 16'h0010, 32'h0000_0015);
		add_instr(opx_pkg::ALU_ADD, 4'd14, 4'd0, 4'd1, 1'b0, 16'h0000, 32'h0000_0005);
		add_instr(opx_pkg::ALU_MOVB, 4'd15, 4'd0, 4'd12, 1'b0, 16'h0000, 32'h0000_0051);
		add_instr(opx_pkg::ALU_OR, 4'd3, 4'd0, 4'd0, 1'b0, 16'h0000, 32'h0000_0000);
		// r10 sat on wb under ex_freeze, read back from the register file
		add_instr(opx_pkg::ALU_MOVB, 4'd15, 4'd0, 4'd10, 1'b0, 16'h0000, 32'h0000_00a0);
	endtask

	task automatic apply_directed();
		int k;
		for (k = 0; k < rows.size(); k++) begin
			@(posedge clk);
			#1;
			issue     = rows[k].iss;
			id_freeze = rows[k].id_frz;
			ex_freeze = rows[k].ex_frz;
			if (!rows[k].id_frz && rows[k].iss.valid && rows[k].chk) begin
				expect_result(1'b0, k, rows[k].iss.rd, rows[k].exp_data);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Random phase
	//////////////////////////////////////////////////

	task automatic run_random();
		int              cyc;
		opx_pkg::issue_t iss;
		opx_pkg::word_t  b;
		cyc = 0;
		while (issued < RAND_COUNT && cyc < RAND_MAX_CYCLES) begin
			@(posedge clk);
			#1;
			// Decode frozen about a quarter of the time, execute half of that
			rng       = xorshift32(rng);
			id_freeze = (rng[1:0] == 2'd0);
			ex_freeze = id_freeze & rng[2];
			rng       = xorshift32(rng);
			// Eight registers only, so hazards are frequent
			iss.valid   = (rng[3:0] != 4'd0);
			iss.op      = opx_pkg::alu_op_t'((rng[6:4] == 3'd7) ? 3'd6 : rng[6:4]);
			iss.rd      = {1'b0, rng[9:7]};
			iss.rs_a    = {1'b0, rng[12:10]};
			iss.rs_b    = {1'b0, rng[15:13]};
			iss.use_imm = rng[16];
			rng         = xorshift32(rng);
			iss.imm     = rng[15:0];
			issue       = iss;
			if (!id_freeze && iss.valid) begin
				// Immediate taken as a signed 16-bit value
				if (iss.use_imm) begin
					b = opx_pkg::word_t'($signed(iss.imm));
				end else begin
					b = model_regs[iss.rs_b];
				end
				expect_result(1'b1, issued, iss.rd,
					alu_ref(iss.op, model_regs[iss.rs_a], b));
				issued++;
			end
			cyc++;
		end
		if (issued < RAND_COUNT) begin
			$display("Timeout: only %0d random instructions issued", issued);
			timeout_count++;
			timed_out = 1'b1;
		end
	endtask

	// Idle inputs until every expected result has come out
	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < limit) begin
			@(posedge clk);
			#1;
			issue     = '0;
			id_freeze = 1'b0;
			ex_freeze = 1'b0;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d results still outstanding", exp_q.size());
			timeout_count++;
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// Result monitor
	//////////////////////////////////////////////////

	// Sampled mid-cycle, well clear of the edge and the input drive
	always @(negedge clk) begin
		if (arst_n) begin
			if (held_last && (wb != wb_last)) begin
				$display("** Error [wb hold]: expected %h, actual %h", wb_last, wb);
				err_count++;
			end
			if (wb.valid && !ex_freeze) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected result on wb for r%0d with nothing outstanding",
						wb.rd);
					err_count++;
				end else begin
					head = exp_q.pop_front();
					check_count++;
					if ((wb.rd != head.rd) || (wb.data != head.data)) begin
						$display("** Error [%s #%0d]: expected r%0d=%h, actual r%0d=%h",
							head.rnd ? "random" : "directed", head.num,
							head.rd, head.data, wb.rd, wb.data);
						err_count++;
					end
				end
			end
			wb_last   = wb;
			held_last = ex_freeze;
		end
	end

	initial begin
		clk           = 1'b0;
		arst_n        = 1'b0;
		id_freeze     = 1'b0;
		ex_freeze     = 1'b0;
		issue         = '0;
		rng           = 32'h7f58_d2cb;
		err_count     = 0;
		timeout_count = 0;
		check_count   = 0;
		issued        = 0;
		timed_out     = 1'b0;
		wb_last       = '0;
		held_last     = 1'b0;
		model_regs    = '{default: '0};
		build_table();
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		apply_directed();
		drain(DRAIN_TIMEOUT);
		if (!timed_out) begin
			run_random();
			drain(DRAIN_TIMEOUT);
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d",
			check_count, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/opx_core_props.sv
/*
 * Concurrent checks bound into operand_mux.
 * The writeback destination is rebuilt here from ex_ctl,
 * as operand_mux only sees the wb data.
 */

`include "opx_defines.svh"

module opx_core_props (
	input logic              clk,
	input logic              arst_n,
	input logic              id_freeze,
	input logic              ex_freeze,
	input opx_pkg::fwd_sel_t sel_a,
	input opx_pkg::ex_ctl_t  ex_ctl
);

	// Shadow of the writeback destination
	logic               wb_valid_s;
	opx_pkg::reg_addr_t wb_rd_s;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid_s <= 1'b0;
			wb_rd_s    <= '0;
		end else if (!ex_freeze) begin
			wb_valid_s <= ex_ctl.valid;
			wb_rd_s    <= ex_ctl.rd;
		end
	end

	freeze_order: assert property (@(posedge clk) disable iff (!arst_n)
		ex_freeze |-> id_freeze)
		else $error("ex_freeze high while id_freeze low");

	// Decode alone frozen puts a bubble into execute
	bubble_after_id_freeze: assert property (@(posedge clk) disable iff (!arst_n)
		(id_freeze && !ex_freeze) |=> !ex_ctl.valid)
		else $error("ex_ctl valid after a decode-only freeze");

	// A forward needs a live nonzero destination, so r0 never matches
	ex_fwd_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
		(sel_a == `OPX_SEL_EX_FORW) |-> (ex_ctl.valid && (ex_ctl.rd != '0)))
		else $error("sel_a picks EX forward without a nonzero EX destination");

	wb_fwd_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
		(sel_a == `OPX_SEL_WB_FORW) |-> (wb_valid_s && (wb_rd_s != '0)))
		else $error("sel_a picks WB forward without a nonzero WB destination");

endmodule

//--- design/opx_core.sv
/*
 * Top level of the four-stage datapath.
 * ex_freeze must only be high together with id_freeze.
 * Each result leaves on wb once, in issue order.
 */

module opx_core (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            id_freeze,
	input  logic            ex_freeze,
	input  opx_pkg::issue_t issue,
	output opx_pkg::wb_t    wb
);

	// Decode to register file
	opx_pkg::reg_addr_t rf_raddr_a;
	opx_pkg::reg_addr_t rf_raddr_b;
	opx_pkg::word_t     rf_dataa;
	opx_pkg::word_t     rf_datab;

	// Decode to operand select
	opx_pkg::word_t    simm;
	opx_pkg::fwd_sel_t sel_a;
	opx_pkg::fwd_sel_t sel_b;
	opx_pkg::id_ex_t   id_ex;

	// Operand select to execute
	opx_pkg::word_t   operand_a;
	opx_pkg::word_t   operand_b;
	opx_pkg::ex_ctl_t ex_ctl;

	// Execute back toward decode
	opx_pkg::word_t   ex_forw;
	opx_pkg::hazard_t hazard;

	// Write blocked while execute is held
	reg_file reg_file_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.raddr_a (rf_raddr_a),
		.raddr_b (rf_raddr_b),
		.rdata_a (rf_dataa),
		.rdata_b (rf_datab),
		.wr      (wb),
		.wr_hold (ex_freeze)
	);

	decode_stage decode_stage_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.id_freeze  (id_freeze),
		.issue      (issue),
		.hazard     (hazard),
		.rf_raddr_a (rf_raddr_a),
		.rf_raddr_b (rf_raddr_b),
		.rf_dataa   (rf_dataa),
		.rf_datab   (rf_datab),
		.simm       (simm),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.id_ex      (id_ex)
	);

	// WB forward is the writeback data field
	operand_mux operand_mux_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb.data),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.id_ex     (id_ex),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_ctl    (ex_ctl)
	);

	alu_stage alu_stage_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.ex_freeze (ex_freeze),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_ctl    (ex_ctl),
		.ex_forw   (ex_forw),
		.wb        (wb),
		.hazard    (hazard)
	);

endmodule

//--- design/alu_stage.sv
/*
 * Execute stage with the ALU and the writeback register.
 * SLL shifts by the low 5 bits of operand B.
 * Unused op encodings give zero.
 * The writeback register holds while ex_freeze is high.
 */

module alu_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             ex_freeze,
	input  opx_pkg::word_t   operand_a,
	input  opx_pkg::word_t   operand_b,
	input  opx_pkg::ex_ctl_t ex_ctl,
	output opx_pkg::word_t   ex_forw,
	output opx_pkg::wb_t     wb,
	output opx_pkg::hazard_t hazard
);

	opx_pkg::word_t     alu_res;
	logic               wb_valid_q;
	opx_pkg::reg_addr_t wb_rd_q;
	opx_pkg::word_t     wb_data_q;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (ex_ctl.op)
			opx_pkg::ALU_ADD:  alu_res = operand_a + operand_b;
			opx_pkg::ALU_SUB:  alu_res = operand_a - operand_b;
			opx_pkg::ALU_AND:  alu_res = operand_a & operand_b;
			opx_pkg::ALU_OR:   alu_res = operand_a | operand_b;
			opx_pkg::ALU_XOR:  alu_res = operand_a ^ operand_b;
			opx_pkg::ALU_SLL:  alu_res = operand_a << operand_b[4:0];
			opx_pkg::ALU_MOVB: alu_res = operand_b;
			default:           alu_res = '0;
		endcase
	end

	// EX forward path straight off the ALU
	assign ex_forw = alu_res;

	//////////////////////////////////////////////////
	// Writeback register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid_q <= 1'b0;
		end else if (!ex_freeze) begin
			wb_valid_q <= ex_ctl.valid;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_rd_q   <= ex_ctl.rd;
			wb_data_q <= alu_res;
		end
	end

	assign wb.valid = wb_valid_q;
	assign wb.rd    = wb_rd_q;
	assign wb.data  = wb_data_q;

	// In-flight destinations for decode
	assign hazard.ex_valid = ex_ctl.valid;
	assign hazard.ex_rd    = ex_ctl.rd;
	assign hazard.wb_valid = wb_valid_q;
	assign hazard.wb_rd    = wb_rd_q;

endmodule

//--- design/operand_mux.sv
/*
 * Operand select with forwarding muxes and the operand registers.
 * ex_freeze holds the operands and ex_ctl.
 * With only id_freeze high the operands are captured once and a bubble
 * enters execute. The saved value is used when both freezes drop.
 */

`include "opx_defines.svh"

module operand_mux (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	input  opx_pkg::word_t    rf_dataa,
	input  opx_pkg::word_t    rf_datab,
	input  opx_pkg::word_t    ex_forw,
	input  opx_pkg::word_t    wb_forw,
	input  opx_pkg::word_t    simm,
	input  opx_pkg::fwd_sel_t sel_a,
	input  opx_pkg::fwd_sel_t sel_b,
	input  opx_pkg::id_ex_t   id_ex,
	output opx_pkg::word_t    operand_a,
	output opx_pkg::word_t    operand_b,
	output opx_pkg::ex_ctl_t  ex_ctl
);

	// Index 0 is operand A, index 1 is operand B
	opx_pkg::word_t muxed [2];
	opx_pkg::word_t opnd_q [2];
	logic           saved_q [2];
	logic           ex_valid_q;
	opx_pkg::alu_op_t   ex_op_q;
	opx_pkg::reg_addr_t ex_rd_q;

	//////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////

	always_comb begin
		case (sel_a)
			`OPX_SEL_EX_FORW: muxed[0] = ex_forw;
			`OPX_SEL_WB_FORW: muxed[0] = wb_forw;
			default:          muxed[0] = rf_dataa;
		endcase
		// B also takes the immediate
		case (sel_b)
			`OPX_SEL_IMM:     muxed[1] = simm;
			`OPX_SEL_EX_FORW: muxed[1] = ex_forw;
			`OPX_SEL_WB_FORW: muxed[1] = wb_forw;
			default:          muxed[1] = rf_datab;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers with saved flags
	//////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_opnd
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				opnd_q[i]  <= '0;
				saved_q[i] <= 1'b0;
			end else if (!ex_freeze) begin
				if (!saved_q[i]) begin
					// Capture, and mark saved if decode is stuck
					opnd_q[i]  <= muxed[i];
					saved_q[i] <= id_freeze;
				end else if (!id_freeze) begin
					// Saved value moves into execute now
					saved_q[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

	// Execute control
	// Bubble when only decode is frozen
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid_q <= 1'b0;
		end else if (!ex_freeze) begin
			ex_valid_q <= id_ex.valid && !id_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_op_q <= id_ex.op;
			ex_rd_q <= id_ex.rd;
		end
	end

	assign ex_ctl.valid = ex_valid_q;
	assign ex_ctl.op    = ex_op_q;
	assign ex_ctl.rd    = ex_rd_q;

endmodule

//--- design/decode_stage.sv
/*
 * Decode stage with the ID register and forwarding source selection.
 * The ID register holds while id_freeze is high and issue is ignored then.
 * Forwarding compares against execute first, then writeback.
 * Register 0 is never a forwarding source.
 */

`include "opx_defines.svh"

module decode_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               id_freeze,
	input  opx_pkg::issue_t    issue,
	input  opx_pkg::hazard_t   hazard,
	output opx_pkg::reg_addr_t rf_raddr_a,
	output opx_pkg::reg_addr_t rf_raddr_b,
	input  opx_pkg::word_t     rf_dataa,
	input  opx_pkg::word_t     rf_datab,
	output opx_pkg::word_t     simm,
	output opx_pkg::fwd_sel_t  sel_a,
	output opx_pkg::fwd_sel_t  sel_b,
	output opx_pkg::id_ex_t    id_ex
);

	// ID register split into valid and payload
	logic            id_valid_q;
	opx_pkg::issue_t id_q;

	// Picks the operand source for one register index
	function automatic opx_pkg::fwd_sel_t pick_src(
		input opx_pkg::reg_addr_t rs,
		input opx_pkg::hazard_t   hz
	);
		if (rs == '0) begin
			return `OPX_SEL_RF;
		end
		// Youngest producer wins
		if (hz.ex_valid && (hz.ex_rd == rs)) begin
			return `OPX_SEL_EX_FORW;
		end
		if (hz.wb_valid && (hz.wb_rd == rs)) begin
			return `OPX_SEL_WB_FORW;
		end
		return `OPX_SEL_RF;
	endfunction

	//////////////////////////////////////////////////
	// ID register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid_q <= 1'b0;
		end else if (!id_freeze) begin
			id_valid_q <= issue.valid;
		end
	end

	// Payload follows the same enable
	always_ff @(posedge clk) begin
		if (!id_freeze) begin
			id_q <= issue;
		end
	end

	// Register file addressing straight from the ID register
	assign rf_raddr_a = id_q.rs_a;
	assign rf_raddr_b = id_q.rs_b;

	// Sign-extend the 16-bit immediate
	assign simm = {{(`OPX_WIDTH-16){id_q.imm[15]}}, id_q.imm};

	// Operand source selects
	assign sel_a = pick_src(id_q.rs_a, hazard);
	assign sel_b = id_q.use_imm ? `OPX_SEL_IMM : pick_src(id_q.rs_b, hazard);

	// Control toward operand select
	assign id_ex.valid = id_valid_q;
	assign id_ex.op    = id_q.op;
	assign id_ex.rd    = id_q.rd;

endmodule

//--- design/reg_file.sv
/*
 * Register file, two asynchronous read ports and one write port.
 * Register 0 always reads zero and is never written.
 * The write is blocked while wr_hold is high so a held result lands once.
 */

`include "opx_defines.svh"

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  opx_pkg::reg_addr_t raddr_a,
	input  opx_pkg::reg_addr_t raddr_b,
	output opx_pkg::word_t     rdata_a,
	output opx_pkg::word_t     rdata_b,
	input  opx_pkg::wb_t       wr,
	input  logic               wr_hold
);

	// Storage array
	opx_pkg::word_t regs_q [`OPX_REGS];
	logic           wr_en;

	// Write qualifier
	// Held results and register 0 never land
	assign wr_en = wr.valid && !wr_hold && (wr.rd != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `OPX_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en) begin
			regs_q[wr.rd] <= wr.data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Register 0 forced to zero on both ports
	assign rdata_a = (raddr_a == '0) ? '0 : regs_q[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs_q[raddr_b];

endmodule

//--- design/opx_pkg.sv
/*
 * Types shared by all datapath stages.
 * The immediate field is fixed at 16 bits and sign-extended in decode.
 * ALU op encoding values 7 and up are unused and give a zero result.
 */

`include "opx_defines.svh"

package opx_pkg;

	typedef logic [`OPX_WIDTH-1:0] word_t;
	typedef logic [`OPX_RADDR_W-1:0] reg_addr_t;
	typedef logic [1:0] fwd_sel_t;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SLL  = 3'd5,
		ALU_MOVB = 3'd6
	} alu_op_t;

	// Instruction as presented on the issue port
	typedef struct packed {
		logic valid;
		alu_op_t op;
		reg_addr_t rd;
		reg_addr_t rs_a;
		reg_addr_t rs_b;
		logic use_imm;
		logic [15:0] imm;
	} issue_t;

	// Control passed from decode into operand select
	typedef struct packed {
		logic valid;
		alu_op_t op;
		reg_addr_t rd;
	} id_ex_t;

	// Control of the instruction sitting in execute
	typedef struct packed {
		logic valid;
		alu_op_t op;
		reg_addr_t rd;
	} ex_ctl_t;

	// Writeback result
	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		word_t data;
	} wb_t;

	// Destinations still in flight
	typedef struct packed {
		logic ex_valid;
		reg_addr_t ex_rd;
		logic wb_valid;
		reg_addr_t wb_rd;
	} hazard_t;

endpackage

//--- design/opx_defines.svh
/*
 * Widths and forwarding select codes for the operand-select datapath.
 * OPX_RADDR_W must be wide enough to index OPX_REGS registers.
 * Select codes are 2 bits and match fwd_sel_t in the package.
 */

`ifndef OPX_DEFINES_SVH
`define OPX_DEFINES_SVH

// Operand and result width
`define OPX_WIDTH 32

// Register file size and index width
`define OPX_REGS 16
`define OPX_RADDR_W 4

// Operand source select codes
`define OPX_SEL_RF 2'd0
`define OPX_SEL_IMM 2'd1
`define OPX_SEL_EX_FORW 2'd2
`define OPX_SEL_WB_FORW 2'd3

`endif
